/* Makefile */
VERILATOR ?= verilator
TOP       ?= fetch_tb
FLIST     ?= flist.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= Finished with no errors

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* flist.f */
hdl/fetch_pkg.sv
hdl/fetch_intf.sv
hdl/fetch_ctrl.sv
hdl/btb.sv
hdl/addr_trans.sv
hdl/fetch_out.sv
hdl/fetch_top.sv
tests/fetch_checker.sv
tests/fetch_tb.sv

/* hdl/addr_trans.sv */
module addr_trans (
    input  fetch_pkg::u32_t       va,
    input  fetch_pkg::csr_fetch_t rd_csr,
    output fetch_pkg::u32_t       pa,
    output logic                  is_cached,
    output fetch_pkg::excp_code_t excp
);

    logic plv_ok0;
    logic plv_ok1;
    logic hit0;
    logic hit1;

    // A window is usable only at a privilege level it enables.
    assign plv_ok0 = (rd_csr.plv == 2'd0 && rd_csr.dmw0.plv0) ||
                     (rd_csr.plv == 2'd3 && rd_csr.dmw0.plv3);
    assign plv_ok1 = (rd_csr.plv == 2'd0 && rd_csr.dmw1.plv0) ||
                     (rd_csr.plv == 2'd3 && rd_csr.dmw1.plv3);

    assign hit0 = plv_ok0 && (rd_csr.dmw0.vseg == va[31:29]);
    assign hit1 = plv_ok1 && (rd_csr.dmw1.vseg == va[31:29]);

    // Window 0 wins when both match.
    always_comb begin
        if (rd_csr.da) begin
            pa        = va;
            is_cached = 1'b1;
        end else if (hit0) begin
            pa        = {rd_csr.dmw0.pseg, va[28:0]};
            is_cached = rd_csr.dmw0.mat[0];
        end else if (hit1) begin
            pa        = {rd_csr.dmw1.pseg, va[28:0]};
            is_cached = rd_csr.dmw1.mat[0];
        end else begin
            pa        = va;
            is_cached = 1'b0;
        end
    end

    // Alignment fault first, then missing window.
    always_comb begin
        if (va[1:0] != 2'b00) begin
            excp = fetch_pkg::EXCP_ADEF;
        end else if (rd_csr.da || hit0 || hit1) begin
            excp = fetch_pkg::EXCP_NONE;
        end else begin
            excp = fetch_pkg::EXCP_TLBR;
        end
    end

endmodule

/* hdl/btb.sv */
module btb (
    input  logic                clk,
    input  logic                rst_n,
    input  fetch_pkg::btb_upd_t btb_upd,
    btb_if.btb                  bp
);

    logic [fetch_pkg::BTB_ENTRIES-1:0] valid_r;
    logic [fetch_pkg::BTB_TAG_W-1:0]   tag_mem    [fetch_pkg::BTB_ENTRIES];
    fetch_pkg::u32_t                   target_mem [fetch_pkg::BTB_ENTRIES];

    logic [fetch_pkg::BTB_IDX_W-1:0] lk_idx;
    logic [fetch_pkg::BTB_TAG_W-1:0] lk_tag;
    logic [fetch_pkg::BTB_IDX_W-1:0] upd_idx;
    logic [fetch_pkg::BTB_TAG_W-1:0] upd_tag;

    // Registered lookup, compared one cycle later.
    logic                            rd_valid_r;
    logic [fetch_pkg::BTB_TAG_W-1:0] rd_tag_r;
    logic [fetch_pkg::BTB_TAG_W-1:0] lk_tag_r;
    fetch_pkg::u32_t                 rd_target_r;

    assign lk_idx  = bp.lookup_pc[fetch_pkg::BTB_IDX_W+1:2];
    assign lk_tag  = bp.lookup_pc[31:fetch_pkg::BTB_IDX_W+2];
    assign upd_idx = btb_upd.pc[fetch_pkg::BTB_IDX_W+1:2];
    assign upd_tag = btb_upd.pc[31:fetch_pkg::BTB_IDX_W+2];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            valid_r <= '0;
        end else if (btb_upd.valid) begin
            valid_r[upd_idx] <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (btb_upd.valid) begin
            tag_mem[upd_idx]    <= upd_tag;
            target_mem[upd_idx] <= btb_upd.target;
        end
    end

    // Entry is read before any same-cycle update lands.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_valid_r <= 1'b0;
        end else if (!bp.hold) begin
            rd_valid_r <= valid_r[lk_idx];
        end
    end

    always_ff @(posedge clk) begin
        if (!bp.hold) begin
            rd_tag_r    <= tag_mem[lk_idx];
            rd_target_r <= target_mem[lk_idx];
            lk_tag_r    <= lk_tag;
        end
    end

    assign bp.pred_valid = rd_valid_r & (rd_tag_r == lk_tag_r);
    assign bp.pred_npc   = rd_target_r;

endmodule

/* hdl/fetch_ctrl.sv */
module fetch_ctrl (
    input  logic                  clk,
    input  logic                  rst_n,
    input  fetch_pkg::wr_pc_req_t ex_wr_pc_req,
    input  fetch_pkg::wr_pc_req_t excp_wr_pc_req,
    input  logic                  credit_return,
    btb_if.ctrl                   bp,
    pkt_if.src                    po
);

    fetch_pkg::u32_t                pc_r;
    fetch_pkg::u32_t                npc;
    logic [fetch_pkg::CREDIT_W-1:0] credits_r;
    logic                           started_r;
    logic                           redirect;
    logic                           hold;
    logic                           pc_en;
    logic                           issue;

    assign redirect = excp_wr_pc_req.valid | ex_wr_pc_req.valid;

    // First cycle out of reset only primes the BTB lookup.
    assign hold  = ~started_r | ((credits_r == '0) & ~credit_return);
    assign pc_en = ~hold | redirect;
    assign issue = ~hold & ~redirect;

    // Prediction refers to the pc_r loaded at the last edge.
    always_comb begin
        if (excp_wr_pc_req.valid) begin
            npc = excp_wr_pc_req.pc;
        end else if (ex_wr_pc_req.valid) begin
            npc = ex_wr_pc_req.pc;
        end else if (bp.pred_valid) begin
            npc = bp.pred_npc;
        end else begin
            npc = pc_r + 32'd4;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc_r      <= fetch_pkg::RESET_PC;
            started_r <= 1'b0;
        end else begin
            started_r <= 1'b1;
            if (pc_en) begin
                pc_r <= npc;
            end
        end
    end

    // One credit per issued packet, one back per decoder return.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            credits_r <= fetch_pkg::CREDIT_W'(fetch_pkg::CREDIT_INIT);
        end else begin
            case ({issue, credit_return})
                2'b10:   credits_r <= credits_r - 1'b1;
                2'b01:   credits_r <= credits_r + 1'b1;
                default: credits_r <= credits_r;
            endcase
        end
    end

    // BTB repeats its lookup whenever pc_r does not move.
    assign bp.lookup_pc = npc;
    assign bp.hold      = ~pc_en;

    assign po.issue    = issue;
    assign po.pc       = pc_r;
    assign po.pred_npc = npc;
    assign po.kill     = redirect;

endmodule

/* hdl/fetch_intf.sv */
// Prediction path between the PC logic and the BTB.
interface btb_if;
    fetch_pkg::u32_t lookup_pc;
    logic            hold;
    logic            pred_valid;
    fetch_pkg::u32_t pred_npc;

    modport ctrl (
        output lookup_pc,
        output hold,
        input  pred_valid,
        input  pred_npc
    );

    modport btb (
        input  lookup_pc,
        input  hold,
        output pred_valid,
        output pred_npc
    );
endinterface

// Issue path from the PC logic to the output register.
interface pkt_if;
    logic            issue;
    fetch_pkg::u32_t pc;
    fetch_pkg::u32_t pred_npc;
    logic            kill;

    modport src (
        output issue,
        output pc,
        output pred_npc,
        output kill
    );

    modport dst (
        input issue,
        input pc,
        input pred_npc,
        input kill
    );
endinterface

/* hdl/fetch_out.sv */
module fetch_out (
    input  logic                  clk,
    input  logic                  rst_n,
    pkt_if.dst                    pi,
    input  fetch_pkg::u32_t       pa,
    input  logic                  is_cached,
    input  fetch_pkg::excp_code_t excp,
    output logic                  pkt_valid,
    output fetch_pkg::fetch_pkt_t pkt
);

    logic capture;

    // A redirect drops whatever is issued alongside it.
    assign capture = pi.issue & ~pi.kill;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pkt_valid <= 1'b0;
        end else begin
            pkt_valid <= capture;
        end
    end

    // Packet fields only move when a new packet is taken.
    always_ff @(posedge clk) begin
        if (capture) begin
            pkt.pc        <= pi.pc;
            pkt.pa        <= pa;
            pkt.is_cached <= is_cached;
            pkt.excp      <= excp;
            pkt.pred_npc  <= pi.pred_npc;
        end
    end

endmodule

/* hdl/fetch_pkg.sv */
package fetch_pkg;

    // Core word and reset address.
    typedef logic [31:0] u32_t;

    localparam u32_t RESET_PC = 32'h1c00_0000;

    // Decoder buffer slots handed out as credits.
    localparam int CREDIT_INIT = 4;
    localparam int CREDIT_W = $clog2(CREDIT_INIT + 1);

    // Direct-mapped BTB geometry, index from pc[5:2].
    localparam int BTB_ENTRIES = 16;
    localparam int BTB_IDX_W = 4;
    localparam int BTB_TAG_W = 26;

    typedef enum logic [1:0] {
        EXCP_NONE = 2'd0,
        EXCP_ADEF = 2'd1,
        EXCP_TLBR = 2'd2
    } excp_code_t;

    typedef struct packed {
        logic valid;
        u32_t pc;
    } wr_pc_req_t;

    // Training request from the branch unit.
    typedef struct packed {
        logic valid;
        u32_t pc;
        u32_t target;
    } btb_upd_t;

    // One direct-map window.
    typedef struct packed {
        logic [2:0] vseg;
        logic [2:0] pseg;
        logic       plv0;
        logic       plv3;
        logic [1:0] mat;
    } dmw_t;

    typedef struct packed {
        logic       da;
        logic [1:0] plv;
        dmw_t       dmw0;
        dmw_t       dmw1;
    } csr_fetch_t;

    typedef struct packed {
        u32_t       pc;
        u32_t       pa;
        logic       is_cached;
        excp_code_t excp;
        u32_t       pred_npc;
    } fetch_pkt_t;

endpackage

/* hdl/fetch_top.sv */
module fetch_top (
    input  logic                  clk,
    input  logic                  rst_n,
    input  fetch_pkg::wr_pc_req_t ex_wr_pc_req,
    input  fetch_pkg::wr_pc_req_t excp_wr_pc_req,
    input  fetch_pkg::btb_upd_t   btb_upd,
    input  fetch_pkg::csr_fetch_t rd_csr,
    input  logic                  credit_return,
    output logic                  pkt_valid,
    output fetch_pkg::fetch_pkt_t pkt
);

    btb_if bp_if ();
    pkt_if pk_if ();

    fetch_pkg::u32_t       pa;
    logic                  is_cached;
    fetch_pkg::excp_code_t excp;

    fetch_ctrl ctrl_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .ex_wr_pc_req   (ex_wr_pc_req),
        .excp_wr_pc_req (excp_wr_pc_req),
        .credit_return  (credit_return),
        .bp             (bp_if.ctrl),
        .po             (pk_if.src)
    );

    btb btb_i (
        .clk     (clk),
        .rst_n   (rst_n),
        .btb_upd (btb_upd),
        .bp      (bp_if.btb)
    );

    // Translation runs on the PC being issued.
    addr_trans trans_i (
        .va        (pk_if.pc),
        .rd_csr    (rd_csr),
        .pa        (pa),
        .is_cached (is_cached),
        .excp      (excp)
    );

    fetch_out out_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .pi        (pk_if.dst),
        .pa        (pa),
        .is_cached (is_cached),
        .excp      (excp),
        .pkt_valid (pkt_valid),
        .pkt       (pkt)
    );

endmodule

/* tests/fetch_checker.sv */
module fetch_checker (
    input  logic                  clk,
    input  logic                  rst_n,
    input  fetch_pkg::wr_pc_req_t ex_wr_pc_req,
    input  fetch_pkg::wr_pc_req_t excp_wr_pc_req,
    input  fetch_pkg::btb_upd_t   btb_upd,
    input  fetch_pkg::csr_fetch_t rd_csr,
    input  logic                  credit_return,
    input  logic                  pkt_valid,
    input  fetch_pkg::fetch_pkt_t pkt,
    input  int                    step_id,
    input  logic [127:0]          test_name,
    input  int                    exp_pkts,
    input  logic                  done,
    output int                    err_cnt,
    output logic                  report_done
);
    timeunit 1ns;
    timeprecision 1ps;

    fetch_pkg::u32_t       exp_pc;
    fetch_pkg::csr_fetch_t csr_d;
    logic                  bt_v  [16];
    logic [25:0]           bt_tag[16];
    fetch_pkg::u32_t       bt_tgt[16];

    int           att_step = -1;
    int           att_exp = -1;
    logic [127:0] att_name = '0;
    int           step_pkts = 0;
    int           test_pkts = 0;
    int           test_errs = 0;
    int           total_pkts = 0;
    int           n_tests = 0;
    int           rst_pkts = 0;
    int           rtn_cnt = 0;

    initial begin
        err_cnt     = 0;
        report_done = 1'b0;
    end

    task automatic count_error();
        err_cnt   = err_cnt + 1;
        test_errs = test_errs + 1;
    endtask

    task automatic clear_model();
        exp_pc   = fetch_pkg::RESET_PC;
        rst_pkts = 0;
        rtn_cnt  = 0;
        for (int i = 0; i < 16; i++) begin
            bt_v[i] = 1'b0;
        end
    endtask

    // Direct mode, then window 0, then window 1.
    task automatic translate_addr(input fetch_pkg::u32_t va, input fetch_pkg::csr_fetch_t c,
                                  output fetch_pkg::u32_t pa, output logic cached,
                                  output fetch_pkg::excp_code_t ex);
        logic ok0;
        logic ok1;
        ok0 = (c.dmw0.vseg == va[31:29]) &&
              ((c.plv == 2'd0 && c.dmw0.plv0) || (c.plv == 2'd3 && c.dmw0.plv3));
        ok1 = (c.dmw1.vseg == va[31:29]) &&
              ((c.plv == 2'd0 && c.dmw1.plv0) || (c.plv == 2'd3 && c.dmw1.plv3));
        pa     = va;
        cached = 1'b0;
        ex     = fetch_pkg::EXCP_TLBR;
        if (c.da) begin
            cached = 1'b1;
            ex     = fetch_pkg::EXCP_NONE;
        end else if (ok0) begin
            pa     = {c.dmw0.pseg, va[28:0]};
            cached = c.dmw0.mat[0];
            ex     = fetch_pkg::EXCP_NONE;
        end else if (ok1) begin
            pa     = {c.dmw1.pseg, va[28:0]};
            cached = c.dmw1.mat[0];
            ex     = fetch_pkg::EXCP_NONE;
        end
        if (va[1:0] != 2'b00) begin
            ex = fetch_pkg::EXCP_ADEF;
        end
    endtask

    function automatic fetch_pkg::u32_t predict_target(input fetch_pkg::u32_t pc);
        if (bt_v[pc[5:2]] && bt_tag[pc[5:2]] == pc[31:6]) begin
            return bt_tgt[pc[5:2]];
        end
        return pc + 32'd4;
    endfunction

    function automatic string format_packet(input fetch_pkg::fetch_pkt_t p);
        return $sformatf("pc=%h pa=%h c=%b ex=%0d npc=%h", p.pc, p.pa, p.is_cached,
                         p.excp, p.pred_npc);
    endfunction

    task automatic check_packet();
        fetch_pkg::fetch_pkt_t e;
        e.pc = exp_pc;
        translate_addr(exp_pc, csr_d, e.pa, e.is_cached, e.excp);
        e.pred_npc = predict_target(exp_pc);
        step_pkts  = step_pkts + 1;
        test_pkts  = test_pkts + 1;
        total_pkts = total_pkts + 1;
        rst_pkts   = rst_pkts + 1;
        if (e != pkt) begin
            $display("CHECK FAILED %0s: expected %s actual %s",
                     att_name, format_packet(e), format_packet(pkt));
            count_error();
        end
        if (rst_pkts > fetch_pkg::CREDIT_INIT + rtn_cnt) begin
            $display("Test %0s: packet arrived without a free decoder credit", att_name);
            count_error();
        end
        exp_pc = e.pred_npc;
    endtask

    task automatic close_step(input logic last);
        if (att_step >= 0) begin
            if (att_exp >= 0 && step_pkts != att_exp) begin
                $display("CHECK FAILED %0s: packet count expected %0d actual %0d",
                         att_name, att_exp, step_pkts);
                count_error();
            end
            if (last || test_name != att_name) begin
                $display("Test %0s: %0d packets, %0d errors", att_name, test_pkts, test_errs);
                n_tests   = n_tests + 1;
                test_pkts = 0;
                test_errs = 0;
            end
        end
        step_pkts = 0;
    endtask

    // Packets seen here were issued in the cycle before the last edge.
    always @(posedge clk) begin
        if (!rst_n) begin
            clear_model();
        end else begin
            if (pkt_valid) begin
                check_packet();
            end
            if (credit_return) begin
                rtn_cnt = rtn_cnt + 1;
            end
            if (btb_upd.valid) begin
                bt_v[btb_upd.pc[5:2]]   = 1'b1;
                bt_tag[btb_upd.pc[5:2]] = btb_upd.pc[31:6];
                bt_tgt[btb_upd.pc[5:2]] = btb_upd.target;
            end
            if (excp_wr_pc_req.valid) begin
                exp_pc = excp_wr_pc_req.pc;
            end else if (ex_wr_pc_req.valid) begin
                exp_pc = ex_wr_pc_req.pc;
            end
        end
        csr_d = rd_csr;
        if (step_id != att_step) begin
            close_step(1'b0);
            att_step = step_id;
            att_exp  = exp_pkts;
            att_name = test_name;
        end
        if (done && !report_done) begin
            close_step(1'b1);
            $display("Summary: %0d tests, %0d packets, %0d errors", n_tests, total_pkts,
                     err_cnt);
            report_done = 1'b1;
        end
    end

endmodule

/* tests/fetch_tb.sv */
module fetch_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int MAX_STEPS = 64;

    logic                  clk;
    logic                  rst_n;
    fetch_pkg::wr_pc_req_t ex_wr_pc_req;
    fetch_pkg::wr_pc_req_t excp_wr_pc_req;
    fetch_pkg::btb_upd_t   btb_upd;
    fetch_pkg::csr_fetch_t rd_csr;
    logic                  credit_return;
    logic                  pkt_valid;
    fetch_pkg::fetch_pkt_t pkt;

    // Step table loaded from the data file.
    logic [127:0]    st_name [MAX_STEPS];
    int              st_rst  [MAX_STEPS];
    logic [22:0]     st_csr  [MAX_STEPS];
    int              st_ex_v [MAX_STEPS];
    fetch_pkg::u32_t st_ex_pc[MAX_STEPS];
    int              st_xc_v [MAX_STEPS];
    fetch_pkg::u32_t st_xc_pc[MAX_STEPS];
    int              st_up_v [MAX_STEPS];
    fetch_pkg::u32_t st_up_pc[MAX_STEPS];
    fetch_pkg::u32_t st_up_tg[MAX_STEPS];
    int              st_mode [MAX_STEPS];
    int              st_cyc  [MAX_STEPS];
    int              st_exp  [MAX_STEPS];
    int              n_steps;

    int           seed;
    int           limit;
    int           cycles;
    int           rcv_cnt;
    int           ret_cnt;
    int           step_id;
    int           exp_pkts;
    logic [127:0] test_name;
    logic         done;
    logic         report_done;
    logic         file_ok;
    int           err_cnt;

    fetch_top dut_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .ex_wr_pc_req   (ex_wr_pc_req),
        .excp_wr_pc_req (excp_wr_pc_req),
        .btb_upd        (btb_upd),
        .rd_csr         (rd_csr),
        .credit_return  (credit_return),
        .pkt_valid      (pkt_valid),
        .pkt            (pkt)
    );

    fetch_checker chk_i (
        .clk            (clk),
        .rst_n          (rst_n),
        .ex_wr_pc_req   (ex_wr_pc_req),
        .excp_wr_pc_req (excp_wr_pc_req),
        .btb_upd        (btb_upd),
        .rd_csr         (rd_csr),
        .credit_return  (credit_return),
        .pkt_valid      (pkt_valid),
        .pkt            (pkt),
        .step_id        (step_id),
        .test_name      (test_name),
        .exp_pkts       (exp_pkts),
        .done           (done),
        .err_cnt        (err_cnt),
        .report_done    (report_done)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Packets the model decoder holds until it frees their slots.
    always @(posedge clk) begin
        if (!rst_n) begin
            rcv_cnt = 0;
        end else if (pkt_valid) begin
            rcv_cnt = rcv_cnt + 1;
        end
    end

    // Run budget in clock cycles, known once the steps are loaded.
    initial begin
        cycles = 0;
        while (cycles <= limit) begin
            @(posedge clk);
            cycles = cycles + 1;
        end
        $display("Timeout: simulation ran past %0d cycles", limit);
        $display("Finished with errors");
        $finish;
    end

    function automatic logic [127:0] name_bits(input string s);
        logic [127:0] b;
        int           i;
        b = '0;
        for (i = 0; i < s.len() && i < 16; i++) begin
            b = {b[119:0], s.getc(i)};
        end
        return b;
    endfunction

    task automatic load_steps(output logic ok);
        int    fd;
        int    cnt;
        string line;
        string nm;
        n_steps = 0;
        limit   = 50;
        fd = $fopen("tests/fetch_tests.txt", "r");
        ok = (fd != 0);
        if (ok) begin
            while (!$feof(fd) && n_steps < MAX_STEPS) begin
                cnt = $fgets(line, fd);
                if (cnt > 1 && line.getc(0) != "#") begin
                    cnt = $sscanf(line, "%s %d %h %d %h %d %h %d %h %h %d %d %d", nm,
                                  st_rst[n_steps], st_csr[n_steps], st_ex_v[n_steps],
                                  st_ex_pc[n_steps], st_xc_v[n_steps], st_xc_pc[n_steps],
                                  st_up_v[n_steps], st_up_pc[n_steps], st_up_tg[n_steps],
                                  st_mode[n_steps], st_cyc[n_steps], st_exp[n_steps]);
                    if (cnt == 13) begin
                        st_name[n_steps] = name_bits(nm);
                        limit = limit + st_cyc[n_steps] + 2 * st_rst[n_steps];
                        n_steps = n_steps + 1;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    // Pulses go out only in the first cycle of a step.
    task automatic drive_cycle(input int s, input int c);
        int rnd;
        ex_wr_pc_req.valid   = (c == 0) && (st_ex_v[s] != 0);
        ex_wr_pc_req.pc      = st_ex_pc[s];
        excp_wr_pc_req.valid = (c == 0) && (st_xc_v[s] != 0);
        excp_wr_pc_req.pc    = st_xc_pc[s];
        btb_upd.valid        = (c == 0) && (st_up_v[s] != 0);
        btb_upd.pc           = st_up_pc[s];
        btb_upd.target       = st_up_tg[s];
        rnd = $random(seed);
        if (rcv_cnt - ret_cnt <= 0) begin
            credit_return = 1'b0;
        end else if (st_mode[s] == 1) begin
            credit_return = 1'b1;
        end else if (st_mode[s] == 2) begin
            credit_return = rnd[0];
        end else begin
            credit_return = 1'b0;
        end
        if (credit_return) begin
            ret_cnt = ret_cnt + 1;
        end
    endtask

    task automatic run_steps();
        for (int s = 0; s < n_steps; s++) begin
            step_id   = s;
            test_name = st_name[s];
            exp_pkts  = st_exp[s];
            rd_csr    = st_csr[s];
            if (st_rst[s] != 0) begin
                credit_return = 1'b0;
                rst_n         = 1'b0;
                ret_cnt       = 0;
                repeat (2) @(negedge clk);
                rst_n = 1'b1;
            end
            for (int c = 0; c < st_cyc[s]; c++) begin
                drive_cycle(s, c);
                @(negedge clk);
            end
        end
    endtask

    initial begin
        seed           = 32'h7ed8_a426;
        rcv_cnt        = 0;
        ret_cnt        = 0;
        step_id        = -1;
        exp_pkts       = -1;
        test_name      = name_bits("reset");
        done           = 1'b0;
        rst_n          = 1'b0;
        ex_wr_pc_req   = '0;
        excp_wr_pc_req = '0;
        btb_upd        = '0;
        rd_csr         = 23'h400000;
        credit_return  = 1'b0;
        load_steps(file_ok);
        if (!file_ok) begin
            $display("Cannot open tests/fetch_tests.txt");
            $display("Finished with errors");
            $finish;
        end else begin
            repeat (2) @(posedge clk);
            @(negedge clk);
            rst_n = 1'b1;
            run_steps();
            step_id        = n_steps;
            test_name      = name_bits("drain");
            exp_pkts       = -1;
            ex_wr_pc_req   = '0;
            excp_wr_pc_req = '0;
            btb_upd        = '0;
            credit_return  = 1'b0;
            repeat (4) @(negedge clk);
            done = 1'b1;
            wait (report_done);
            if (err_cnt == 0) begin
                $display("Finished with no errors");
            end else begin
                $display("Finished with errors");
            end
            $finish;
        end
    end

endmodule

/* tests/fetch_tests.txt */
# name rst csr(da,plv,dmw0,dmw1) ex_v ex_pc xc_v xc_pc up_v up_pc up_target
# credit mode (0 none, 1 every cycle, 2 random), cycles, expected packets (-1 any)
reset_seq     0 400000 0 0        0 0        0 0        0        1 20 -1
credit_stall  1 400000 0 0        0 0        0 0        0        0 12 4
credit_stall  0 400000 0 0        0 0        0 0        0        1 12 -1
credit_random 0 400000 0 0        0 0        0 0        0        2 40 -1
ex_redirect   0 400000 1 1c001000 0 0        0 0        0        1 10 -1
excp_priority 0 400000 1 1c002000 1 1c003000 0 0        0        1 10 -1
btb_hit       0 400000 1 1c0000f0 0 0        1 1c000100 1c000200 1 16 -1
mapped_dmw0   0 016788 1 1c004000 0 0        0 0        0        1 10 -1
mapped_dmw1   0 016788 1 e0001000 0 0        0 0        0        1 10 -1
mapped_tlbr   0 016788 1 40000000 0 0        0 0        0        1 10 -1
mapped_adef   0 016788 1 1c000102 0 0        0 0        0        1 10 -1
back_to_da    0 400000 1 1c000000 0 0        0 0        0        1 12 -1
